//--- Bender.yml
package:
  name: wts

sources:
  - source/wts_pkg.sv
  - source/wts_slot_sequencer.sv
  - source/wts_phase_gen.sv
  - source/wts_wave_ram.sv
  - source/wts_voice_scale.sv
  - source/wts_mix_accum.sv
  - source/wts_top.sv
  - target: test
    files:
      - dv/wts_assertions.sv
      - dv/wts_tb.sv

//--- dv/wts_assertions.sv
`default_nettype none

module wts_assertions (
	input wire                logic clk,
	input wire                logic nreset,
	input wts_pkg::slot_tag_t tag_seq,
	input wts_pkg::slot_tag_t tag_mix,
	input wire                logic cpu_busy,
	input wire                logic cpu_rdata_valid,
	input wire                logic [wts_pkg::MIX_W-1:0] left_out,
	input wire                logic [wts_pkg::MIX_W-1:0] right_out
);

	timeunit 1ns;
	timeprecision 1ps;

	logic mix_last;
	int   fail_count = 0;

	assign mix_last = tag_mix.valid && tag_mix.last && (tag_mix.kind == wts_pkg::VOICE);

	// The CPU slot closes every frame
	cpu_after_last: assert property (@(posedge clk) disable iff (!nreset)
		(tag_seq.valid && tag_seq.last) |=> (tag_seq.kind == wts_pkg::CPU))
		else begin
			$error("slot after the last voice is not the CPU slot");
			fail_count++;
		end

	rdata_not_busy: assert property (@(posedge clk) disable iff (!nreset)
		!(cpu_rdata_valid && cpu_busy))
		else begin
			$error("cpu_rdata_valid high while cpu_busy is high");
			fail_count++;
		end

	out_after_last: assert property (@(posedge clk) disable iff (!nreset)
		($changed(left_out) || $changed(right_out)) |-> $past(mix_last))
		else begin
			$error("mixer outputs changed outside the cycle after a last tag");
			fail_count++;
		end

endmodule

bind wts_top wts_assertions u_assert (
	.clk             (clk),
	.nreset          (nreset),
	.tag_seq         (tag_seq),
	.tag_mix         (tag_mix),
	.cpu_busy        (cpu_busy),
	.cpu_rdata_valid (cpu_rdata_valid),
	.left_out        (left_out),
	.right_out       (right_out)
);

`default_nettype wire

//--- dv/wts_tb.sv
`default_nettype none

module wts_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_VOICES = 6;
	localparam int FRAME      = NUM_VOICES + 1;
	localparam int SETTLE     = 2 * FRAME + 5;
	localparam int TIMEOUT    = 4 * FRAME;
	localparam int WAVE_LEN   = 2 ** wts_pkg::WAVE_LEN_LOG2;
	localparam int SEED       = 32'h13477d31;

	logic                                 clk;
	logic                                 nreset;
	logic [NUM_VOICES-1:0]                key_on;
	wts_pkg::voice_cfg_t [NUM_VOICES-1:0] voice_cfg;
	wts_pkg::cpu_req_t                    cpu_req;
	logic                                 cpu_busy;
	logic [wts_pkg::SAMPLE_W-1:0]         cpu_rdata;
	logic                                 cpu_rdata_valid;
	logic [wts_pkg::MIX_W-1:0]            left_out;
	logic [wts_pkg::MIX_W-1:0]            right_out;

	// Model copy of the wave RAM
	logic [wts_pkg::SAMPLE_W-1:0] model_ram [2 ** wts_pkg::RAM_ADDR_W];

	string test_name;
	int    errors;
	int    test_errors;
	int    tests_run;
	int    tests_failed;
	bit    aborted;

	wts_top #(.NUM_VOICES(NUM_VOICES)) dut0 (
		.clk             (clk),
		.nreset          (nreset),
		.key_on          (key_on),
		.voice_cfg       (voice_cfg),
		.cpu_req         (cpu_req),
		.cpu_busy        (cpu_busy),
		.cpu_rdata       (cpu_rdata),
		.cpu_rdata_valid (cpu_rdata_valid),
		.left_out        (left_out),
		.right_out       (right_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// ----------------------------------------------------------------------
	// Model and compare tasks
	// ----------------------------------------------------------------------

	function automatic int scale_sample(input logic [wts_pkg::SAMPLE_W-1:0] s,
			input logic [3:0] volume);
		int prod;
		prod = int'($signed(s)) * int'(volume);
		return prod >>> 4;
	endfunction

	// All voices read the same sample index and silent voices add nothing
	function automatic logic [wts_pkg::MIX_W-1:0] mix_model(input int index, input bit left_side);
		int                             sum;
		int                             pan_bit;
		logic [wts_pkg::RAM_ADDR_W-1:0] addr;
		sum     = 0;
		pan_bit = left_side ? 1 : 0;
		for (int v = 0; v < NUM_VOICES; v++) begin
			addr = {wts_pkg::SLOT_W'(v), wts_pkg::WAVE_LEN_LOG2'(index % WAVE_LEN)};
			if (voice_cfg[v].pan[pan_bit]) begin
				sum += scale_sample(model_ram[addr], voice_cfg[v].volume);
			end
		end
		return wts_pkg::MIX_W'(sum + 2 ** (wts_pkg::MIX_W - 1));
	endfunction

	task automatic check_sample(input logic [wts_pkg::SAMPLE_W-1:0] expected,
			input logic [wts_pkg::SAMPLE_W-1:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s expected %02h actual %02h", test_name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_mix(input logic [wts_pkg::MIX_W-1:0] exp_left,
			input logic [wts_pkg::MIX_W-1:0] exp_right);
		if (left_out !== exp_left || right_out !== exp_right) begin
			$display("[FAIL] %s expected %03h/%03h actual %03h/%03h", test_name,
				exp_left, exp_right, left_out, right_out);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string flag, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s expected %b actual %b", test_name, flag, expected, actual);
			test_errors++;
		end
	endtask

	// ----------------------------------------------------------------------
	// Drivers
	// ----------------------------------------------------------------------

	task automatic next_cycle(input int n);
		repeat (n) begin
			@(posedge clk);
			#5;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("%s: timed out after %0d cycles waiting for %s", test_name, TIMEOUT, what);
		test_errors++;
		aborted = 1'b1;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (cpu_busy !== 1'b0) begin
			if (n == TIMEOUT) begin
				report_timeout("cpu_busy to fall");
				return;
			end
			next_cycle(1);
			n++;
		end
	endtask

	task automatic issue_request(input wts_pkg::cpu_op_e op, input int voice, input int index,
			input logic [wts_pkg::SAMPLE_W-1:0] wdata);
		wait_idle();
		if (aborted) begin
			return;
		end
		cpu_req.op    = op;
		cpu_req.voice = wts_pkg::SLOT_W'(voice);
		cpu_req.index = wts_pkg::WAVE_LEN_LOG2'(index);
		cpu_req.wdata = wdata;
		next_cycle(1);
		cpu_req.op = wts_pkg::IDLE;
		check_flag("cpu_busy", 1'b1, cpu_busy);
	endtask

	task automatic cpu_write(input int voice, input int index,
			input logic [wts_pkg::SAMPLE_W-1:0] data);
		issue_request(wts_pkg::WRITE, voice, index, data);
		model_ram[{wts_pkg::SLOT_W'(voice), wts_pkg::WAVE_LEN_LOG2'(index)}] = data;
	endtask

	task automatic cpu_read(input int voice, input int index);
		int n;
		issue_request(wts_pkg::READ, voice, index, '0);
		n = 0;
		while (!aborted && cpu_rdata_valid !== 1'b1) begin
			if (n == TIMEOUT) begin
				report_timeout("cpu_rdata_valid");
				return;
			end
			next_cycle(1);
			n++;
		end
		if (!aborted) begin
			check_sample(model_ram[{wts_pkg::SLOT_W'(voice), wts_pkg::WAVE_LEN_LOG2'(index)}],
				cpu_rdata);
		end
	endtask

	task automatic pulse_key(input logic [NUM_VOICES-1:0] mask);
		key_on = mask;
		next_cycle(1);
		key_on = '0;
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("%s: done, %0d errors", test_name, test_errors);
	endtask

	// ----------------------------------------------------------------------
	// Tests
	// ----------------------------------------------------------------------

	task automatic test_cpu_access();
		for (int v = 0; v < NUM_VOICES && !aborted; v++) begin
			for (int i = 0; i < WAVE_LEN && !aborted; i++) begin
				cpu_write(v, i, wts_pkg::SAMPLE_W'($urandom));
			end
		end
		for (int r = 0; r < 64 && !aborted; r++) begin
			cpu_read($urandom_range(NUM_VOICES - 1), $urandom_range(WAVE_LEN - 1));
		end
	endtask

	task automatic test_static_mix();
		for (int round = 0; round < 4; round++) begin
			for (int v = 0; v < NUM_VOICES; v++) begin
				voice_cfg[v].freq   = '0;
				voice_cfg[v].volume = 4'($urandom);
				voice_cfg[v].pan    = 2'($urandom);
			end
			pulse_key('1);
			next_cycle(SETTLE);
			check_mix(mix_model(0, 1'b1), mix_model(0, 1'b0));
		end
	endtask

	task automatic test_volume_pan();
		for (int v = 0; v < NUM_VOICES; v++) begin
			voice_cfg[v].volume = '0;
			voice_cfg[v].pan    = 2'b11;
		end
		pulse_key('1);
		next_cycle(SETTLE);
		check_mix(12'h800, 12'h800);
		// Left side muted, then right side muted
		for (int v = 0; v < NUM_VOICES; v++) begin
			voice_cfg[v].volume = 4'($urandom_range(15, 8));
			voice_cfg[v].pan    = 2'b01;
		end
		next_cycle(SETTLE);
		check_mix(12'h800, mix_model(0, 1'b0));
		for (int v = 0; v < NUM_VOICES; v++) begin
			voice_cfg[v].pan = 2'b10;
		end
		next_cycle(SETTLE);
		check_mix(mix_model(0, 1'b1), 12'h800);
	endtask

	task automatic test_advance();
		logic [wts_pkg::MIX_W-1:0] left_seen [$];
		logic [wts_pkg::MIX_W-1:0] right_seen [$];
		int                        voice;
		int                        start;
		voice = $urandom_range(NUM_VOICES - 1);
		for (int i = 0; i < WAVE_LEN && !aborted; i++) begin
			cpu_write(voice, i, wts_pkg::SAMPLE_W'(i * 8 - 128));
		end
		if (aborted) begin
			return;
		end
		for (int v = 0; v < NUM_VOICES; v++) begin
			voice_cfg[v] = '0;
		end
		voice_cfg[voice].volume = 4'd15;
		voice_cfg[voice].pan    = 2'b11;
		voice_cfg[voice].freq   = 12'd1;
		pulse_key('1);
		next_cycle(SETTLE);
		for (int c = 0; c < 40 * FRAME; c++) begin
			if (left_seen.size() == 0 || left_out !== left_seen[$] ||
					right_out !== right_seen[$]) begin
				left_seen.push_back(left_out);
				right_seen.push_back(right_out);
			end
			next_cycle(1);
		end
		start = -1;
		for (int k = 0; k < WAVE_LEN; k++) begin
			if (start < 0 && mix_model(k, 1'b1) === left_seen[0]) begin
				start = k;
			end
		end
		if (start < 0 || left_seen.size() <= WAVE_LEN) begin
			$display("%s: the outputs did not step through the ramp wave", test_name);
			test_errors++;
			return;
		end
		for (int j = 0; j < left_seen.size(); j++) begin
			if (left_seen[j] !== mix_model(start + j, 1'b1) ||
					right_seen[j] !== mix_model(start + j, 1'b0)) begin
				$display("[FAIL] %s expected %03h/%03h actual %03h/%03h", test_name,
					mix_model(start + j, 1'b1), mix_model(start + j, 1'b0),
					left_seen[j], right_seen[j]);
				test_errors++;
			end
		end
	endtask

	initial begin
		void'($urandom(SEED));
		nreset       = 1'b0;
		key_on       = '0;
		voice_cfg    = '0;
		cpu_req      = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		aborted      = 1'b0;

		start_test("reset");
		next_cycle(8);
		check_mix(12'h800, 12'h800);
		check_flag("cpu_busy", 1'b0, cpu_busy);
		check_flag("cpu_rdata_valid", 1'b0, cpu_rdata_valid);
		nreset = 1'b1;
		finish_test();

		start_test("cpu_access");
		test_cpu_access();
		finish_test();
		if (!aborted) begin
			start_test("static_mix");
			test_static_mix();
			finish_test();
			start_test("volume_pan");
			test_volume_pan();
			finish_test();
			start_test("advance");
			test_advance();
			finish_test();
		end

		if (dut0.u_assert.fail_count != 0) begin
			$display("%0d assertions on the DUT failed during the run",
				dut0.u_assert.fail_count);
			errors += dut0.u_assert.fail_count;
		end

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
source/wts_pkg.sv
source/wts_slot_sequencer.sv
source/wts_phase_gen.sv
source/wts_wave_ram.sv
source/wts_voice_scale.sv
source/wts_mix_accum.sv
source/wts_top.sv
dv/wts_assertions.sv
dv/wts_tb.sv

//--- source/wts_mix_accum.sv
`default_nettype none

module wts_mix_accum (
	input  wire                logic clk,
	input  wire                logic nreset,
	input  wts_pkg::slot_tag_t tag_in,
	input  wts_pkg::stereo_t   scaled,
	output logic [wts_pkg::MIX_W-1:0] left_out,
	output logic [wts_pkg::MIX_W-1:0] right_out
);

	localparam logic [wts_pkg::MIX_W-1:0] SILENCE = {1'b1, {(wts_pkg::MIX_W-1){1'b0}}};

	logic signed [wts_pkg::MIX_W-1:0] left_ext;
	logic signed [wts_pkg::MIX_W-1:0] right_ext;
	logic signed [wts_pkg::MIX_W-1:0] left_acc;
	logic signed [wts_pkg::MIX_W-1:0] right_acc;
	logic signed [wts_pkg::MIX_W-1:0] left_sum;
	logic signed [wts_pkg::MIX_W-1:0] right_sum;
	logic                             voice_slot;

	assign voice_slot = tag_in.valid && (tag_in.kind == wts_pkg::VOICE);

	assign left_ext  = wts_pkg::MIX_W'(scaled.left);
	assign right_ext = wts_pkg::MIX_W'(scaled.right);

	// The first voice of a frame starts a fresh sum
	assign left_sum  = (tag_in.first ? '0 : left_acc) + left_ext;
	assign right_sum = (tag_in.first ? '0 : right_acc) + right_ext;

	always_ff @(posedge clk) begin
		if (voice_slot) begin
			left_acc  <= left_sum;
			right_acc <= right_sum;
		end
	end

	// ----------------------------------------------------------------------
	// Offset-binary outputs, updated once per frame
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!nreset) begin
			left_out  <= SILENCE;
			right_out <= SILENCE;
		end else if (voice_slot && tag_in.last) begin
			left_out  <= {~left_sum[wts_pkg::MIX_W-1], left_sum[wts_pkg::MIX_W-2:0]};
			right_out <= {~right_sum[wts_pkg::MIX_W-1], right_sum[wts_pkg::MIX_W-2:0]};
		end
	end

endmodule

`default_nettype wire

//--- source/wts_phase_gen.sv
`default_nettype none

module wts_phase_gen #(
	parameter int NUM_VOICES = 6
) (
	input  wire                 logic clk,
	input  wire                 logic nreset,
	input  wts_pkg::slot_tag_t  tag_in,
	input  wire                 logic [NUM_VOICES-1:0] key_on,
	input  wts_pkg::voice_cfg_t [NUM_VOICES-1:0] voice_cfg,
	output wts_pkg::slot_tag_t  tag_out,
	output logic [wts_pkg::RAM_ADDR_W-1:0] ram_addr
);

	logic [wts_pkg::WAVE_LEN_LOG2-1:0] idx [NUM_VOICES];
	logic [11:0]                       cnt [NUM_VOICES];
	logic [NUM_VOICES-1:0]             key_pend;
	logic [NUM_VOICES-1:0]             key_clr;

	logic [wts_pkg::SLOT_W-1:0] v;
	logic                       voice_slot;
	logic                       key_hit;
	wts_pkg::voice_cfg_t        cfg;

	assign v          = tag_in.slot;
	assign voice_slot = tag_in.valid && (tag_in.kind == wts_pkg::VOICE);
	assign cfg        = voice_cfg[v];
	assign key_hit    = key_on[v] | key_pend[v];

	// A key-on pulse may come at any time and waits for its voice slot
	always_comb begin
		key_clr = '0;
		if (voice_slot) begin
			key_clr[v] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			key_pend <= '0;
		end else begin
			key_pend <= (key_pend | key_on) & ~key_clr;
		end
	end

	// ----------------------------------------------------------------------
	// Sample index and frequency down-counter of the voice in this slot
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!nreset) begin
			for (int i = 0; i < NUM_VOICES; i++) begin
				idx[i] <= '0;
				cnt[i] <= '0;
			end
		end else if (voice_slot) begin
			if (key_hit) begin
				idx[v] <= '0;
				cnt[v] <= cfg.freq;
			end else if (cfg.freq == '0) begin
				cnt[v] <= '0;
			end else if (cnt[v] <= 12'd1) begin
				cnt[v] <= cfg.freq;
				idx[v] <= idx[v] + 1'b1;
			end else begin
				cnt[v] <= cnt[v] - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			tag_out <= '0;
		end else begin
			tag_out <= tag_in;
		end
	end

	always_ff @(posedge clk) begin
		ram_addr <= {v, key_hit ? '0 : idx[v]};
	end

endmodule

`default_nettype wire

//--- source/wts_pkg.sv
`default_nettype none

package wts_pkg;

	// ----------------------------------------------------------------------
	// Sizes
	// ----------------------------------------------------------------------

	// Seven voices and the CPU slot fill a 3-bit slot index
	parameter int MAX_VOICES    = 7;
	parameter int SLOT_W        = 3;
	parameter int WAVE_LEN_LOG2 = 5;

	// Wave RAM address is {slot, sample index}
	parameter int RAM_ADDR_W    = SLOT_W + WAVE_LEN_LOG2;
	parameter int SAMPLE_W      = 8;
	parameter int MIX_W         = 12;

	// ----------------------------------------------------------------------
	// Encodings
	// ----------------------------------------------------------------------

	typedef enum logic {
		VOICE = 1'b0,
		CPU   = 1'b1
	} slot_kind_e;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		READ  = 2'd1,
		WRITE = 2'd2
	} cpu_op_e;

	// ----------------------------------------------------------------------
	// Bundles
	// ----------------------------------------------------------------------

	// Follows each sample down the pipeline
	typedef struct packed {
		logic              valid;
		slot_kind_e        kind;
		logic [SLOT_W-1:0] slot;
		logic              first;
		logic              last;
	} slot_tag_t;

	// Pan bit 1 feeds the left side, bit 0 the right side
	typedef struct packed {
		logic [3:0]  volume;
		logic [1:0]  pan;
		logic [11:0] freq;
	} voice_cfg_t;

	typedef struct packed {
		cpu_op_e                  op;
		logic [SLOT_W-1:0]        voice;
		logic [WAVE_LEN_LOG2-1:0] index;
		logic [SAMPLE_W-1:0]      wdata;
	} cpu_req_t;

	typedef struct packed {
		logic signed [8:0] left;
		logic signed [8:0] right;
	} stereo_t;

endpackage

`default_nettype wire

//--- source/wts_slot_sequencer.sv
`default_nettype none

module wts_slot_sequencer #(
	parameter int NUM_VOICES = 6
) (
	input  wire                logic clk,
	input  wire                logic nreset,
	output wts_pkg::slot_tag_t tag
);

	localparam logic [wts_pkg::SLOT_W-1:0] LAST_VOICE = wts_pkg::SLOT_W'(NUM_VOICES - 1);
	localparam logic [wts_pkg::SLOT_W-1:0] CPU_SLOT   = wts_pkg::SLOT_W'(NUM_VOICES);

	logic [wts_pkg::SLOT_W-1:0] slot_cnt;
	logic                       at_cpu;

	assign at_cpu = (slot_cnt == CPU_SLOT);

	// Frame counter, voices 0 to NUM_VOICES-1 and then the CPU slot
	always_ff @(posedge clk) begin
		if (!nreset) begin
			slot_cnt <= '0;
		end else if (at_cpu) begin
			slot_cnt <= '0;
		end else begin
			slot_cnt <= slot_cnt + 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// Tag register
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!nreset) begin
			tag <= '0;
		end else begin
			tag.valid <= 1'b1;
			tag.kind  <= at_cpu ? wts_pkg::CPU : wts_pkg::VOICE;
			tag.slot  <= slot_cnt;
			tag.first <= (slot_cnt == '0);
			// With a single voice the first voice is the last one as well
			tag.last  <= (slot_cnt == LAST_VOICE);
		end
	end

endmodule

`default_nettype wire

//--- source/wts_top.sv
`default_nettype none

module wts_top #(
	parameter int NUM_VOICES = 6
) (
	input  wire                 logic clk,
	input  wire                 logic nreset,
	input  wire                 logic [NUM_VOICES-1:0] key_on,
	input  wts_pkg::voice_cfg_t [NUM_VOICES-1:0] voice_cfg,
	input  wts_pkg::cpu_req_t   cpu_req,
	output logic                cpu_busy,
	output logic [wts_pkg::SAMPLE_W-1:0] cpu_rdata,
	output logic                cpu_rdata_valid,
	output logic [wts_pkg::MIX_W-1:0] left_out,
	output logic [wts_pkg::MIX_W-1:0] right_out
);

	if (NUM_VOICES < 1 || NUM_VOICES > wts_pkg::MAX_VOICES) begin : g_bad_voices
		$error("NUM_VOICES must lie between 1 and MAX_VOICES");
	end

	wts_pkg::slot_tag_t tag_seq;
	wts_pkg::slot_tag_t tag_ph;
	wts_pkg::slot_tag_t tag_ram;
	wts_pkg::slot_tag_t tag_mix;

	logic [wts_pkg::RAM_ADDR_W-1:0] ram_addr;
	logic [wts_pkg::SAMPLE_W-1:0]   sample;
	wts_pkg::stereo_t               scaled;

	// ----------------------------------------------------------------------
	// Sequencer, phase, RAM, scale and mix, one cycle each
	// ----------------------------------------------------------------------

	wts_slot_sequencer #(.NUM_VOICES(NUM_VOICES)) u_seq (
		.clk    (clk),
		.nreset (nreset),
		.tag    (tag_seq)
	);

	wts_phase_gen #(.NUM_VOICES(NUM_VOICES)) u_phase (
		.clk       (clk),
		.nreset    (nreset),
		.tag_in    (tag_seq),
		.key_on    (key_on),
		.voice_cfg (voice_cfg),
		.tag_out   (tag_ph),
		.ram_addr  (ram_addr)
	);

	wts_wave_ram u_ram (
		.clk             (clk),
		.nreset          (nreset),
		.tag_in          (tag_ph),
		.ram_addr        (ram_addr),
		.cpu_req         (cpu_req),
		.cpu_busy        (cpu_busy),
		.cpu_rdata       (cpu_rdata),
		.cpu_rdata_valid (cpu_rdata_valid),
		.tag_out         (tag_ram),
		.sample          (sample)
	);

	wts_voice_scale #(.NUM_VOICES(NUM_VOICES)) u_scale (
		.clk       (clk),
		.nreset    (nreset),
		.tag_in    (tag_ram),
		.sample    (sample),
		.voice_cfg (voice_cfg),
		.tag_out   (tag_mix),
		.scaled    (scaled)
	);

	wts_mix_accum u_mix (
		.clk       (clk),
		.nreset    (nreset),
		.tag_in    (tag_mix),
		.scaled    (scaled),
		.left_out  (left_out),
		.right_out (right_out)
	);

endmodule

`default_nettype wire

//--- source/wts_voice_scale.sv
`default_nettype none

module wts_voice_scale #(
	parameter int NUM_VOICES = 6
) (
	input  wire                 logic clk,
	input  wire                 logic nreset,
	input  wts_pkg::slot_tag_t  tag_in,
	input  wire                 logic [wts_pkg::SAMPLE_W-1:0] sample,
	input  wts_pkg::voice_cfg_t [NUM_VOICES-1:0] voice_cfg,
	output wts_pkg::slot_tag_t  tag_out,
	output wts_pkg::stereo_t    scaled
);

	wts_pkg::voice_cfg_t               cfg;
	logic signed [wts_pkg::SAMPLE_W+4:0] prod;
	logic signed [8:0]                 part;
	logic                              voice_slot;

	assign voice_slot = tag_in.valid && (tag_in.kind == wts_pkg::VOICE);
	assign cfg        = voice_cfg[tag_in.slot];

	// Signed sample times unsigned volume, then an arithmetic shift by 4
	assign prod = $signed(sample) * $signed({1'b0, cfg.volume});
	assign part = prod[wts_pkg::SAMPLE_W+4:4];

	always_ff @(posedge clk) begin
		scaled.left  <= (voice_slot && cfg.pan[1]) ? part : '0;
		scaled.right <= (voice_slot && cfg.pan[0]) ? part : '0;
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			tag_out <= '0;
		end else begin
			tag_out <= tag_in;
		end
	end

endmodule

`default_nettype wire

//--- source/wts_wave_ram.sv
`default_nettype none

module wts_wave_ram (
	input  wire                logic clk,
	input  wire                logic nreset,
	input  wts_pkg::slot_tag_t tag_in,
	input  wire                logic [wts_pkg::RAM_ADDR_W-1:0] ram_addr,
	input  wts_pkg::cpu_req_t  cpu_req,
	output logic               cpu_busy,
	output logic [wts_pkg::SAMPLE_W-1:0] cpu_rdata,
	output logic               cpu_rdata_valid,
	output wts_pkg::slot_tag_t tag_out,
	output logic [wts_pkg::SAMPLE_W-1:0] sample
);

	localparam int DEPTH = 2 ** wts_pkg::RAM_ADDR_W;

	logic [wts_pkg::SAMPLE_W-1:0]   mem [DEPTH];
	logic [wts_pkg::SAMPLE_W-1:0]   rd_q;
	logic [wts_pkg::RAM_ADDR_W-1:0] addr;

	wts_pkg::cpu_req_t pend;
	logic              cpu_slot;
	logic              do_cpu;
	logic              do_write;

	// ----------------------------------------------------------------------
	// Pending CPU access
	// ----------------------------------------------------------------------

	assign cpu_busy = (pend.op != wts_pkg::IDLE);
	assign cpu_slot = tag_in.valid && (tag_in.kind == wts_pkg::CPU);
	assign do_cpu   = cpu_slot && cpu_busy;
	assign do_write = do_cpu && (pend.op == wts_pkg::WRITE);

	// Held until the next CPU slot, new requests are dropped meanwhile
	always_ff @(posedge clk) begin
		if (!nreset) begin
			pend <= '0;
		end else if (do_cpu) begin
			pend.op <= wts_pkg::IDLE;
		end else if (!cpu_busy && (cpu_req.op != wts_pkg::IDLE)) begin
			pend <= cpu_req;
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			cpu_rdata_valid <= 1'b0;
		end else begin
			cpu_rdata_valid <= do_cpu && (pend.op == wts_pkg::READ);
		end
	end

	// ----------------------------------------------------------------------
	// Single-port array, the CPU owns the port during its slot
	// ----------------------------------------------------------------------

	assign addr = do_cpu ? {pend.voice, pend.index} : ram_addr;

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[addr] <= pend.wdata;
		end
		rd_q <= mem[addr];
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			tag_out <= '0;
		end else begin
			tag_out <= tag_in;
		end
	end

	// One read register serves the voices and the CPU
	assign sample    = rd_q;
	assign cpu_rdata = rd_q;

endmodule

`default_nettype wire
